//--- jtag_tap_pkg.sv
//////////////////////////////////////////////////
// TAP controller state encoding
// Internal strobe struct and top-level status struct
//////////////////////////////////////////////////

package jtag_tap_pkg;

	// Binary state codes of the sixteen TAP states
	// Test-Logic-Reset at F and Run-Test-Idle at C
	typedef enum logic [3:0] {
		ST_EXIT2_DR         = 4'h0,
		ST_EXIT1_DR         = 4'h1,
		ST_SHIFT_DR         = 4'h2,
		ST_PAUSE_DR         = 4'h3,
		ST_SELECT_IR        = 4'h4,
		ST_UPDATE_DR        = 4'h5,
		ST_CAPTURE_DR       = 4'h6,
		ST_SELECT_DR        = 4'h7,
		ST_EXIT2_IR         = 4'h8,
		ST_EXIT1_IR         = 4'h9,
		ST_SHIFT_IR         = 4'hA,
		ST_PAUSE_IR         = 4'hB,
		ST_RUN_TEST_IDLE    = 4'hC,
		ST_UPDATE_IR        = 4'hD,
		ST_CAPTURE_IR       = 4'hE,
		ST_TEST_LOGIC_RESET = 4'hF
	} tap_state_e;

	// One-hot strobes that steer the IR and DR blocks
	typedef struct packed {
		logic tlr;
		logic run_test_idle;
		logic capture_dr;
		logic shift_dr;
		logic pause_dr;
		logic update_dr;
		logic capture_ir;
		logic shift_ir;
		logic update_ir;
	} tap_ctrl_t;

	// Strobes visible at the chip boundary
	typedef struct packed {
		logic tlr;
		logic run_test_idle;
		logic capture_dr;
		logic shift_dr;
		logic pause_dr;
		logic update_dr;
		logic shift_ir;
		logic update_ir;
	} tap_status_t;

endpackage

//--- jtag_instr_pkg.sv
//////////////////////////////////////////////////
// JTAG instruction set and IR and IDCODE types
// Instruction select and external chain structs
//////////////////////////////////////////////////

package jtag_instr_pkg;

	// Instruction register width
	localparam int IR_LENGTH = 4;

	typedef logic [IR_LENGTH-1:0] ir_t;

	// Supported opcodes
	localparam ir_t OP_EXTEST         = 4'b0000;
	localparam ir_t OP_SAMPLE_PRELOAD = 4'b0001;
	localparam ir_t OP_IDCODE         = 4'b0010;
	localparam ir_t OP_DEBUG          = 4'b1000;
	localparam ir_t OP_MBIST          = 4'b1001;
	localparam ir_t OP_BYPASS         = 4'b1111;

	// Fixed pattern loaded in Capture-IR
	// Low two bits 01 as required by the standard
	localparam ir_t IR_CAPTURE = 4'b0101;

	// Device identification word
	typedef logic [31:0] idcode_t;

	localparam idcode_t IDCODE_VALUE = 32'h149511C3;

	// One-hot data register selects
	typedef struct packed {
		logic extest;
		logic sample_preload;
		logic idcode;
		logic mbist;
		logic debug;
		logic bypass;
	} instr_sel_t;

	// Serial outputs of the chains outside the TAP
	typedef struct packed {
		logic debug;
		logic bs_chain;
		logic mbist;
	} chain_tdo_t;

endpackage

//--- tap_state_machine.sv
//////////////////////////////////////////////////
// TAP controller FSM
// State register, TMS next-state table, state strobes
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tap_state_machine
(
	input  logic                    dif,
	input  logic                    test_logic_reset,
	input  logic                    tms_i,
	output jtag_tap_pkg::tap_ctrl_t tap_ctrl_o
);

	import jtag_tap_pkg::*;

	// Present state
	tap_state_e state_q;
	// State taken at the next rising edge
	tap_state_e state_d;

	//////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////

	// One state step per TMS bit
	always_ff @(posedge dif)
	begin
		if (test_logic_reset)
		begin
			state_q <= ST_TEST_LOGIC_RESET;
		end
		else
		begin
			state_q <= state_d;
		end
	end

	//////////////////////////////////////////////////
	// Next-state table
	//////////////////////////////////////////////////

	always_comb
	begin
		case (state_q)
			// Idle and reset states
			ST_TEST_LOGIC_RESET:
				state_d = tms_i ? ST_TEST_LOGIC_RESET : ST_RUN_TEST_IDLE;
			ST_RUN_TEST_IDLE:
				state_d = tms_i ? ST_SELECT_DR : ST_RUN_TEST_IDLE;

			// Data register column
			ST_SELECT_DR:
				state_d = tms_i ? ST_SELECT_IR : ST_CAPTURE_DR;
			ST_CAPTURE_DR:
				state_d = tms_i ? ST_EXIT1_DR : ST_SHIFT_DR;
			ST_SHIFT_DR:
				state_d = tms_i ? ST_EXIT1_DR : ST_SHIFT_DR;
			ST_EXIT1_DR:
				state_d = tms_i ? ST_UPDATE_DR : ST_PAUSE_DR;
			ST_PAUSE_DR:
				state_d = tms_i ? ST_EXIT2_DR : ST_PAUSE_DR;
			// Exit2 may go back into shifting
			ST_EXIT2_DR:
				state_d = tms_i ? ST_UPDATE_DR : ST_SHIFT_DR;
			ST_UPDATE_DR:
				state_d = tms_i ? ST_SELECT_DR : ST_RUN_TEST_IDLE;

			// Instruction register column
			// TMS high in Select-IR escapes to reset
			ST_SELECT_IR:
				state_d = tms_i ? ST_TEST_LOGIC_RESET : ST_CAPTURE_IR;
			ST_CAPTURE_IR:
				state_d = tms_i ? ST_EXIT1_IR : ST_SHIFT_IR;
			ST_SHIFT_IR:
				state_d = tms_i ? ST_EXIT1_IR : ST_SHIFT_IR;
			ST_EXIT1_IR:
				state_d = tms_i ? ST_UPDATE_IR : ST_PAUSE_IR;
			ST_PAUSE_IR:
				state_d = tms_i ? ST_EXIT2_IR : ST_PAUSE_IR;
			ST_EXIT2_IR:
				state_d = tms_i ? ST_UPDATE_IR : ST_SHIFT_IR;
			ST_UPDATE_IR:
				state_d = tms_i ? ST_SELECT_DR : ST_RUN_TEST_IDLE;

			// Any stray code falls back to reset
			default:
				state_d = ST_TEST_LOGIC_RESET;
		endcase
	end

	//////////////////////////////////////////////////
	// State strobes
	//////////////////////////////////////////////////

	// Purely combinational decode of the present state
	assign tap_ctrl_o.tlr           = (state_q == ST_TEST_LOGIC_RESET);
	assign tap_ctrl_o.run_test_idle = (state_q == ST_RUN_TEST_IDLE);
	assign tap_ctrl_o.capture_dr    = (state_q == ST_CAPTURE_DR);
	assign tap_ctrl_o.shift_dr      = (state_q == ST_SHIFT_DR);
	assign tap_ctrl_o.pause_dr      = (state_q == ST_PAUSE_DR);
	assign tap_ctrl_o.update_dr     = (state_q == ST_UPDATE_DR);
	assign tap_ctrl_o.capture_ir    = (state_q == ST_CAPTURE_IR);
	assign tap_ctrl_o.shift_ir      = (state_q == ST_SHIFT_IR);
	assign tap_ctrl_o.update_ir     = (state_q == ST_UPDATE_IR);

endmodule

//--- tap_instruction_reg.sv
//////////////////////////////////////////////////
// JTAG instruction register
// IR shift stage, latched instruction, opcode decode
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tap_instruction_reg
(
	input  logic                       dif,
	input  logic                       test_logic_reset,
	input  logic                       tdi_i,
	input  jtag_tap_pkg::tap_ctrl_t    tap_ctrl_i,
	output logic                       ir_tdo_o,
	output jtag_instr_pkg::instr_sel_t instr_sel_o
);

	import jtag_instr_pkg::*;

	// Serial stage between TDI and TDO
	ir_t ir_shift;
	// Instruction in force
	ir_t ir_latched;

	// Capture pattern or shift LSB first
	always_ff @(posedge dif)
	begin
		if (test_logic_reset || tap_ctrl_i.tlr)
		begin
			ir_shift <= '0;
		end
		else if (tap_ctrl_i.capture_ir)
		begin
			ir_shift <= IR_CAPTURE;
		end
		else if (tap_ctrl_i.shift_ir)
		begin
			// TDI enters at the top bit
			ir_shift <= {tdi_i, ir_shift[IR_LENGTH-1:1]};
		end
	end

	// Bit 0 leaves first
	assign ir_tdo_o = ir_shift[0];

	// New instruction takes effect on the edge leaving Update-IR
	// IDCODE is the instruction after reset
	always_ff @(posedge dif)
	begin
		if (test_logic_reset || tap_ctrl_i.tlr)
		begin
			ir_latched <= OP_IDCODE;
		end
		else if (tap_ctrl_i.update_ir)
		begin
			ir_latched <= ir_shift;
		end
	end

	// Opcode decode to one-hot selects
	always_comb
	begin
		instr_sel_o = '0;
		case (ir_latched)
			OP_EXTEST:         instr_sel_o.extest         = 1'b1;
			OP_SAMPLE_PRELOAD: instr_sel_o.sample_preload = 1'b1;
			OP_IDCODE:         instr_sel_o.idcode         = 1'b1;
			OP_MBIST:          instr_sel_o.mbist          = 1'b1;
			OP_DEBUG:          instr_sel_o.debug          = 1'b1;
			OP_BYPASS:         instr_sel_o.bypass         = 1'b1;
			// Unknown opcodes put the device in bypass
			default:           instr_sel_o.bypass         = 1'b1;
		endcase
	end

endmodule

//--- tap_data_regs.sv
//////////////////////////////////////////////////
// JTAG test data registers
// 32-bit IDCODE register and 1-bit bypass register
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tap_data_regs
(
	input  logic                       dif,
	input  logic                       test_logic_reset,
	input  logic                       tdi_i,
	input  jtag_tap_pkg::tap_ctrl_t    tap_ctrl_i,
	input  jtag_instr_pkg::instr_sel_t instr_sel_i,
	output logic                       idcode_tdo_o,
	output logic                       bypass_tdo_o
);

	import jtag_instr_pkg::*;

	idcode_t idcode_reg;
	logic    bypass_reg;

	// IDCODE register
	// Reloads the ID word on capture and shifts right on shift
	always_ff @(posedge dif)
	begin
		if (test_logic_reset || tap_ctrl_i.tlr)
		begin
			idcode_reg <= IDCODE_VALUE;
		end
		else if (instr_sel_i.idcode && tap_ctrl_i.capture_dr)
		begin
			idcode_reg <= IDCODE_VALUE;
		end
		else if (instr_sel_i.idcode && tap_ctrl_i.shift_dr)
		begin
			idcode_reg <= {tdi_i, idcode_reg[$bits(idcode_t)-1:1]};
		end
	end

	assign idcode_tdo_o = idcode_reg[0];

	// Bypass bit
	// Captures 0 so the first bit out marks the bypass path
	always_ff @(posedge dif)
	begin
		if (test_logic_reset || tap_ctrl_i.tlr)
		begin
			bypass_reg <= 1'b0;
		end
		else if (instr_sel_i.bypass && tap_ctrl_i.capture_dr)
		begin
			bypass_reg <= 1'b0;
		end
		else if (instr_sel_i.bypass && tap_ctrl_i.shift_dr)
		begin
			bypass_reg <= tdi_i;
		end
	end

	assign bypass_tdo_o = bypass_reg;

endmodule

//--- tap_tdo_mux.sv
//////////////////////////////////////////////////
// TDO source multiplexer
// Falling-edge TDO register and TDO output enable
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tap_tdo_mux
(
	input  logic                       dif,
	input  jtag_tap_pkg::tap_ctrl_t    tap_ctrl_i,
	input  jtag_instr_pkg::instr_sel_t instr_sel_i,
	input  logic                       ir_tdo_i,
	input  logic                       idcode_tdo_i,
	input  logic                       bypass_tdo_i,
	input  jtag_instr_pkg::chain_tdo_t chain_tdo_i,
	output logic                       tdo_o,
	output logic                       tdo_oe_o
);

	// Selected serial bit before the output flop
	logic tdo_mux;

	// IR wins during Shift-IR, otherwise the selected data register
	always_comb
	begin
		if (tap_ctrl_i.shift_ir)
			tdo_mux = ir_tdo_i;
		else if (instr_sel_i.idcode)
			tdo_mux = idcode_tdo_i;
		else if (instr_sel_i.debug)
			tdo_mux = chain_tdo_i.debug;
		// Both boundary-scan instructions share one chain
		else if (instr_sel_i.extest || instr_sel_i.sample_preload)
			tdo_mux = chain_tdo_i.bs_chain;
		else if (instr_sel_i.mbist)
			tdo_mux = chain_tdo_i.mbist;
		else if (instr_sel_i.bypass)
			tdo_mux = bypass_tdo_i;
		else
			tdo_mux = 1'b1;
	end

	// TDO changes on the falling edge of dif
	always_ff @(negedge dif)
	begin
		tdo_o <= tdo_mux;
	end

	// Driver enable one cycle behind the shift states
	always_ff @(posedge dif)
	begin
		tdo_oe_o <= tap_ctrl_i.shift_ir | tap_ctrl_i.shift_dr;
	end

endmodule

//--- jtag_tap_top.sv
//////////////////////////////////////////////////
// JTAG TAP controller top level
// FSM, IR, data registers and TDO mux
//////////////////////////////////////////////////

`timescale 1ns/1ns

module jtag_tap_top
(
	input  logic                       dif,
	input  logic                       test_logic_reset,
	input  logic                       tms_i,
	input  logic                       tdi_i,
	input  jtag_instr_pkg::chain_tdo_t chain_tdo_i,
	output logic                       tdo_o,
	output logic                       tdo_oe_o,
	output jtag_tap_pkg::tap_status_t  tap_status_o,
	output jtag_instr_pkg::instr_sel_t instr_sel_o
);

	import jtag_tap_pkg::*;
	import jtag_instr_pkg::*;

	// State strobes from the FSM
	tap_ctrl_t  tap_ctrl;
	// Decoded instruction
	instr_sel_t instr_sel;
	// Serial outputs of the internal registers
	logic       ir_tdo;
	logic       idcode_tdo;
	logic       bypass_tdo;

	tap_state_machine u_fsm (
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tms_i            (tms_i),
		.tap_ctrl_o       (tap_ctrl)
	);

	tap_instruction_reg u_ir (
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tdi_i            (tdi_i),
		.tap_ctrl_i       (tap_ctrl),
		.ir_tdo_o         (ir_tdo),
		.instr_sel_o      (instr_sel)
	);

	tap_data_regs u_dr (
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tdi_i            (tdi_i),
		.tap_ctrl_i       (tap_ctrl),
		.instr_sel_i      (instr_sel),
		.idcode_tdo_o     (idcode_tdo),
		.bypass_tdo_o     (bypass_tdo)
	);

	tap_tdo_mux u_tdo (
		.dif              (dif),
		.tap_ctrl_i       (tap_ctrl),
		.instr_sel_i      (instr_sel),
		.ir_tdo_i         (ir_tdo),
		.idcode_tdo_i     (idcode_tdo),
		.bypass_tdo_i     (bypass_tdo),
		.chain_tdo_i      (chain_tdo_i),
		.tdo_o            (tdo_o),
		.tdo_oe_o         (tdo_oe_o)
	);

	// Boundary view of the strobes
	// Capture-IR stays internal
	assign tap_status_o.tlr           = tap_ctrl.tlr;
	assign tap_status_o.run_test_idle = tap_ctrl.run_test_idle;
	assign tap_status_o.capture_dr    = tap_ctrl.capture_dr;
	assign tap_status_o.shift_dr      = tap_ctrl.shift_dr;
	assign tap_status_o.pause_dr      = tap_ctrl.pause_dr;
	assign tap_status_o.update_dr     = tap_ctrl.update_dr;
	assign tap_status_o.shift_ir      = tap_ctrl.shift_ir;
	assign tap_status_o.update_ir     = tap_ctrl.update_ir;

	assign instr_sel_o = instr_sel;

endmodule

//--- jtag_tap_asserts.sv
//////////////////////////////////////////////////
// Concurrent checks on the TAP top-level outputs
//////////////////////////////////////////////////

`timescale 1ns/1ns

module jtag_tap_asserts
(
	input logic                       dif,
	input logic                       test_logic_reset,
	input jtag_tap_pkg::tap_status_t  tap_status_i,
	input jtag_instr_pkg::instr_sel_t instr_sel_i,
	input logic                       tdo_oe_i
);

	// Number of failed properties, read back at the end of the run
	int assert_errors = 0;

	// At most one state strobe at a time
	status_onehot: assert property (@(posedge dif) disable iff (test_logic_reset)
		$onehot0(tap_status_i))
	else
	begin
		$error("TAP status strobes are not one-hot");
		assert_errors++;
	end

	// At most one instruction select
	select_onehot: assert property (@(posedge dif) disable iff (test_logic_reset)
		$onehot0(instr_sel_i))
	else
	begin
		$error("Instruction selects are not one-hot");
		assert_errors++;
	end

	// Enable is the shift strobe of the previous cycle
	oe_follows_shift: assert property (@(posedge dif) disable iff (test_logic_reset)
		tdo_oe_i == $past(tap_status_i.shift_dr | tap_status_i.shift_ir))
	else
	begin
		$error("TDO enable does not follow the shift states");
		assert_errors++;
	end

	// Reset always lands in Test-Logic-Reset
	tlr_after_reset: assert property (@(posedge dif)
		test_logic_reset |=> tap_status_i.tlr)
	else
	begin
		$error("Test-Logic-Reset not reached after reset");
		assert_errors++;
	end

endmodule

//--- tb_clock_gen.sv
//////////////////////////////////////////////////
// Testbench clock and synchronous reset source
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock_gen
(
	output logic dif,
	output logic test_logic_reset
);

	// 8 ns clock period
	localparam int HALF_PERIOD_NS = 4;
	localparam int RESET_CYCLES   = 4;

	initial
	begin
		dif = 1'b0;
		forever #HALF_PERIOD_NS dif = ~dif;
	end

	// Reset seen high at four rising edges
	// and released 1 ns after the last one
	initial
	begin
		test_logic_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge dif);
		#1;
		test_logic_reset = 1'b0;
	end

endmodule

//--- jtag_tap_tb.sv
//////////////////////////////////////////////////
// Directed tests of the JTAG TAP controller
// Reference TAP FSM model, watchdog, result line
//////////////////////////////////////////////////

`timescale 1ns/1ns

module jtag_tap_tb;

	import jtag_tap_pkg::*;
	import jtag_instr_pkg::*;

	localparam int  PERIOD_NS      = 8;
	localparam int  RESET_CYCLES   = 4;
	localparam int  WALK_STEPS     = 200;
	localparam int  RESET_TRIES    = 20;
	localparam int  BYPASS_BITS    = 24;
	localparam int  CHAIN_BITS     = 16;
	// Cycles of one IR load and the DR entry and exit overhead
	localparam int  IR_LOAD_CYCLES = 10;
	localparam int  DR_OVERHEAD    = 5;
	localparam ir_t OP_UNKNOWN     = 4'b0110;

	// Sum of the cycles of all tests
	localparam int TEST_CYCLES = WALK_STEPS + RESET_TRIES * 12
		+ (1 + DR_OVERHEAD + 32)
		+ 7 * IR_LOAD_CYCLES
		+ (IR_LOAD_CYCLES + 2 * (DR_OVERHEAD + BYPASS_BITS))
		+ 4 * (IR_LOAD_CYCLES + DR_OVERHEAD + CHAIN_BITS);
	localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES + 100) * PERIOD_NS;

	logic        dif;
	logic        test_logic_reset;
	logic        tms;
	logic        tdi;
	chain_tdo_t  chain_tdo;
	logic        tdo;
	logic        tdo_oe;
	tap_status_t tap_status;
	instr_sel_t  instr_sel;

	// Model state, error count, random source
	tap_state_e  ref_state;
	int          errors;
	integer      seed;
	logic [31:0] rnd;

	// Per-bit data of one Shift-DR pass
	logic        tdi_seq   [0:31];
	chain_tdo_t  chain_seq [0:31];
	logic        tdo_seq   [0:31];
	logic        oe_seq    [0:31];

	tb_clock_gen u_clk (
		.dif              (dif),
		.test_logic_reset (test_logic_reset)
	);

	jtag_tap_top uut (
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tms_i            (tms),
		.tdi_i            (tdi),
		.chain_tdo_i      (chain_tdo),
		.tdo_o            (tdo),
		.tdo_oe_o         (tdo_oe),
		.tap_status_o     (tap_status),
		.instr_sel_o      (instr_sel)
	);

	bind jtag_tap_top jtag_tap_asserts u_asserts (
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tap_status_i     (tap_status_o),
		.instr_sel_i      (instr_sel_o),
		.tdo_oe_i         (tdo_oe_o)
	);

	//////////////////////////////////////////////////
	// Reference models
	//////////////////////////////////////////////////

	// IEEE 1149.1 state diagram
	function automatic tap_state_e next_state(input tap_state_e s, input logic t);
		case (s)
			ST_TEST_LOGIC_RESET: return t ? ST_TEST_LOGIC_RESET : ST_RUN_TEST_IDLE;
			ST_RUN_TEST_IDLE:    return t ? ST_SELECT_DR : ST_RUN_TEST_IDLE;
			ST_SELECT_DR:        return t ? ST_SELECT_IR : ST_CAPTURE_DR;
			ST_CAPTURE_DR:       return t ? ST_EXIT1_DR : ST_SHIFT_DR;
			ST_SHIFT_DR:         return t ? ST_EXIT1_DR : ST_SHIFT_DR;
			ST_EXIT1_DR:         return t ? ST_UPDATE_DR : ST_PAUSE_DR;
			ST_PAUSE_DR:         return t ? ST_EXIT2_DR : ST_PAUSE_DR;
			ST_EXIT2_DR:         return t ? ST_UPDATE_DR : ST_SHIFT_DR;
			ST_UPDATE_DR:        return t ? ST_SELECT_DR : ST_RUN_TEST_IDLE;
			ST_SELECT_IR:        return t ? ST_TEST_LOGIC_RESET : ST_CAPTURE_IR;
			ST_CAPTURE_IR:       return t ? ST_EXIT1_IR : ST_SHIFT_IR;
			ST_SHIFT_IR:         return t ? ST_EXIT1_IR : ST_SHIFT_IR;
			ST_EXIT1_IR:         return t ? ST_UPDATE_IR : ST_PAUSE_IR;
			ST_PAUSE_IR:         return t ? ST_EXIT2_IR : ST_PAUSE_IR;
			ST_EXIT2_IR:         return t ? ST_UPDATE_IR : ST_SHIFT_IR;
			ST_UPDATE_IR:        return t ? ST_SELECT_DR : ST_RUN_TEST_IDLE;
			default:             return ST_TEST_LOGIC_RESET;
		endcase
	endfunction

	// Strobes expected at the top level in a given state
	function automatic tap_status_t status_of(input tap_state_e s);
		tap_status_t st;
		st               = '0;
		st.tlr           = (s == ST_TEST_LOGIC_RESET);
		st.run_test_idle = (s == ST_RUN_TEST_IDLE);
		st.capture_dr    = (s == ST_CAPTURE_DR);
		st.shift_dr      = (s == ST_SHIFT_DR);
		st.pause_dr      = (s == ST_PAUSE_DR);
		st.update_dr     = (s == ST_UPDATE_DR);
		st.shift_ir      = (s == ST_SHIFT_IR);
		st.update_ir     = (s == ST_UPDATE_IR);
		return st;
	endfunction

	// Decode table with unknown codes falling into bypass
	function automatic instr_sel_t expected_sel(input ir_t op);
		instr_sel_t sel;
		sel = '0;
		case (op)
			OP_EXTEST:         sel.extest         = 1'b1;
			OP_SAMPLE_PRELOAD: sel.sample_preload = 1'b1;
			OP_IDCODE:         sel.idcode         = 1'b1;
			OP_DEBUG:          sel.debug          = 1'b1;
			OP_MBIST:          sel.mbist          = 1'b1;
			default:           sel.bypass         = 1'b1;
		endcase
		return sel;
	endfunction

	// External chain bit that should reach TDO
	function automatic logic chain_field(input ir_t op, input chain_tdo_t c);
		if (op == OP_DEBUG)
			return c.debug;
		else if (op == OP_MBIST)
			return c.mbist;
		else
			return c.bs_chain;
	endfunction

	//////////////////////////////////////////////////
	// Drive and check helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// One TCK cycle entered and left 1 ns after a rising edge
	// TDO and its enable sampled 1 ns before the next rising edge
	task automatic clock_bit(input logic tms_bit, input logic tdi_bit,
		output logic tdo_bit, output logic oe_bit);
		tms = tms_bit;
		tdi = tdi_bit;
		#(PERIOD_NS - 2);
		tdo_bit = tdo;
		oe_bit  = tdo_oe;
		@(posedge dif);
		#1;
		ref_state = next_state(ref_state, tms_bit);
	endtask

	task automatic move(input logic tms_bit);
		logic tdo_bit;
		logic oe_bit;
		clock_bit(tms_bit, 1'b0, tdo_bit, oe_bit);
	endtask

	// From Run-Test-Idle through Shift-IR and back to Run-Test-Idle
	task automatic load_ir(input ir_t op, output ir_t captured);
		logic tdo_bit;
		logic oe_bit;
		move(1'b1);
		move(1'b1);
		move(1'b0);
		move(1'b0);
		for (int i = 0; i < IR_LENGTH; i++)
		begin
			// Last bit leaves Shift-IR
			clock_bit(i == IR_LENGTH - 1, op[i], tdo_bit, oe_bit);
			captured[i] = tdo_bit;
		end
		move(1'b1);
		move(1'b0);
	endtask

	// From Run-Test-Idle through n Shift-DR cycles and back
	task automatic shift_dr(input int n);
		logic tdo_bit;
		logic oe_bit;
		move(1'b1);
		move(1'b0);
		move(1'b0);
		for (int i = 0; i < n; i++)
		begin
			chain_tdo = chain_seq[i];
			clock_bit(i == n - 1, tdi_seq[i], tdo_bit, oe_bit);
			tdo_seq[i] = tdo_bit;
			oe_seq[i]  = oe_bit;
		end
		chain_tdo = '0;
		move(1'b1);
		move(1'b0);
	endtask

	// Random TDI and chain bits for one pass
	task automatic fill_stimulus(input int n);
		for (int i = 0; i < n; i++)
		begin
			rnd          = $random(seed);
			tdi_seq[i]   = rnd[0];
			chain_seq[i] = chain_tdo_t'(rnd[3:1]);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset_and_fsm();
		int len;
		check_value("reset_status", 32'(status_of(ST_TEST_LOGIC_RESET)), 32'(tap_status));
		check_value("reset_select", 32'(expected_sel(OP_IDCODE)), 32'(instr_sel));
		check_value("reset_tdo_oe", 32'd0, 32'(tdo_oe));
		for (int i = 0; i < WALK_STEPS; i++)
		begin
			rnd = $random(seed);
			move(rnd[0]);
			check_value("fsm_walk", 32'(status_of(ref_state)), 32'(tap_status));
		end
		// Short random prefix and then five ones
		for (int t = 0; t < RESET_TRIES; t++)
		begin
			rnd = $random(seed);
			len = 32'(rnd[2:0]);
			for (int i = 0; i < len; i++)
			begin
				rnd = $random(seed);
				move(rnd[0]);
			end
			repeat (5) move(1'b1);
			check_value("tms_reset", 32'd1, 32'(tap_status.tlr));
		end
	endtask

	task automatic test_idcode();
		idcode_t dout;
		move(1'b0);
		check_value("idcode_select", 32'(expected_sel(OP_IDCODE)), 32'(instr_sel));
		for (int i = 0; i < 32; i++)
		begin
			tdi_seq[i]   = 1'b0;
			chain_seq[i] = '0;
		end
		shift_dr(32);
		for (int i = 0; i < 32; i++)
			dout[i] = tdo_seq[i];
		check_value("idcode_data", IDCODE_VALUE, dout);
		check_value("idcode_oe", 32'd0, 32'(oe_seq[0]));
		for (int i = 1; i < 32; i++)
			check_value("idcode_oe", 32'd1, 32'(oe_seq[i]));
	endtask

	task automatic test_instructions();
		ir_t op_list [0:6];
		ir_t captured;
		op_list = '{OP_EXTEST, OP_SAMPLE_PRELOAD, OP_IDCODE, OP_DEBUG,
			OP_MBIST, OP_BYPASS, OP_UNKNOWN};
		for (int k = 0; k < 7; k++)
		begin
			load_ir(op_list[k], captured);
			check_value("ir_capture", 32'(IR_CAPTURE), 32'(captured));
			check_value("ir_decode", 32'(expected_sel(op_list[k])), 32'(instr_sel));
		end
	endtask

	task automatic test_bypass();
		ir_t captured;
		load_ir(OP_BYPASS, captured);
		// First pass leaves a one in the bypass bit for the next capture to clear
		fill_stimulus(BYPASS_BITS);
		tdi_seq[BYPASS_BITS - 1] = 1'b1;
		shift_dr(BYPASS_BITS);
		fill_stimulus(BYPASS_BITS);
		shift_dr(BYPASS_BITS);
		// Captured zero comes out first
		check_value("bypass_data", 32'd0, 32'(tdo_seq[0]));
		for (int i = 1; i < BYPASS_BITS; i++)
			check_value("bypass_data", 32'(tdi_seq[i - 1]), 32'(tdo_seq[i]));
	endtask

	task automatic test_chains();
		ir_t chain_ops [0:3];
		ir_t captured;
		chain_ops = '{OP_DEBUG, OP_MBIST, OP_EXTEST, OP_SAMPLE_PRELOAD};
		for (int k = 0; k < 4; k++)
		begin
			load_ir(chain_ops[k], captured);
			fill_stimulus(CHAIN_BITS);
			shift_dr(CHAIN_BITS);
			for (int i = 0; i < CHAIN_BITS; i++)
				check_value("chain_data", 32'(chain_field(chain_ops[k], chain_seq[i])),
					32'(tdo_seq[i]));
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence, result and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		tms       = 1'b0;
		tdi       = 1'b0;
		chain_tdo = '0;
		errors    = 0;
		seed      = 33;
		ref_state = ST_TEST_LOGIC_RESET;
		// Start 1 ns after the last reset edge
		@(negedge test_logic_reset);
		test_reset_and_fsm();
		test_idcode();
		test_instructions();
		test_bypass();
		test_chains();
		$display("Errors: %0d check, %0d assertion", errors, uut.u_asserts.assert_errors);
		if (errors == 0 && uut.u_asserts.assert_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- compile.f
jtag_tap_pkg.sv
jtag_instr_pkg.sv
tap_state_machine.sv
tap_instruction_reg.sv
tap_data_regs.sv
tap_tdo_mux.sv
jtag_tap_top.sv
jtag_tap_asserts.sv
tb_clock_gen.sv
jtag_tap_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the JTAG TAP testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module jtag_tap_tb -o sim_jtag_tap

# Keep running after an assertion error so the testbench prints its result
./obj_dir/sim_jtag_tap +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
